// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= decodeTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hdl/*.sv dv/*.sv dv/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/decodeModel.svh ====
/*
	Decode reference model
	Shadow register file and the stage's decode, immediate, destination
	and branch rules, evaluated independently of the DUT
*/

typedef struct packed {
	logic halt;
	logic createDump;
	logic jumpI;
	logic jumpD;
	logic branch;
	logic memWrite;
	logic memRead;
	logic cmpSet;
	logic memToReg;
	logic regWrite;
	logic link;
	logic imm5;
	logic signImm;
	logic aluSrc;
	logic clrAluSrc;
	logic cin;
	logic invA;
	logic invB;
	logic sign;
	logic err;
	decodePkg::regDst_t regDst;
	decodePkg::cmpOp_t cmpOp;
	decodePkg::specialOp_t specialOp;
	decodePkg::aluOp_t aluOp;
} ctrlRef_t;

decodePkg::word_t shadowRegs [0:7];

function automatic ctrlRef_t refDecode(input decodePkg::word_t instr);
	ctrlRef_t r;
	decodePkg::opcode_t op;
	logic [1:0] sel;
	op = decodePkg::opcode_t'(instr[15:11]);
	sel = (op == decodePkg::opAlu || op == decodePkg::opShift) ? instr[1:0] : instr[12:11];
	r = '0;
	r.aluOp = decodePkg::aluAdd;
	case (op)
		decodePkg::opHalt: begin
			r.halt = 1'b1;
			r.createDump = 1'b1;
		end
		decodePkg::opNop: ;
		decodePkg::opAddi, decodePkg::opSubi, decodePkg::opXori, decodePkg::opAndni,
		decodePkg::opAlu: begin
			r.regWrite = 1'b1;
			r.regDst = (op == decodePkg::opAlu) ? decodePkg::dstRd : decodePkg::dstRt;
			r.imm5 = 1'b1;
			r.signImm = (op == decodePkg::opAddi) || (op == decodePkg::opSubi);
			r.aluSrc = (op != decodePkg::opAlu);
			r.invA = (sel == 2'b01);		// subtract flips Rs
			r.cin = (sel == 2'b01);
			r.invB = (sel == 2'b11);		// and-not
			if (sel == 2'b10)
				r.aluOp = decodePkg::aluXor;
			else if (sel == 2'b11)
				r.aluOp = decodePkg::aluAnd;
		end
		decodePkg::opRoli, decodePkg::opSlli, decodePkg::opSrai, decodePkg::opSrli,
		decodePkg::opShift: begin
			r.regWrite = 1'b1;
			r.regDst = (op == decodePkg::opShift) ? decodePkg::dstRd : decodePkg::dstRt;
			r.imm5 = 1'b1;
			r.aluSrc = (op != decodePkg::opShift);
			r.aluOp = {1'b0, sel};
		end
		decodePkg::opSt, decodePkg::opLd, decodePkg::opStu: begin
			r.imm5 = 1'b1;
			r.signImm = 1'b1;
			r.aluSrc = 1'b1;
			r.memRead = (op == decodePkg::opLd);
			r.memToReg = (op == decodePkg::opLd);
			r.memWrite = (op != decodePkg::opLd);
			r.regWrite = (op != decodePkg::opSt);		// stu updates Rs
			r.regDst = (op == decodePkg::opLd) ? decodePkg::dstRt : decodePkg::dstRs;
		end
		decodePkg::opSeq, decodePkg::opSlt, decodePkg::opSle, decodePkg::opSco: begin
			r.regWrite = 1'b1;
			r.regDst = decodePkg::dstRd;
			r.cmpSet = 1'b1;
			r.cmpOp = instr[12:11];
			r.invB = (op != decodePkg::opSco);
			r.cin = (op != decodePkg::opSco);
			r.sign = (op == decodePkg::opSlt) || (op == decodePkg::opSle);
		end
		decodePkg::opBeqz, decodePkg::opBnez, decodePkg::opBltz, decodePkg::opBgez: begin
			r.branch = 1'b1;
			r.signImm = 1'b1;
		end
		decodePkg::opJ, decodePkg::opJr, decodePkg::opJal, decodePkg::opJalr: begin
			r.jumpD = 1'b1;
			r.jumpI = (op == decodePkg::opJr) || (op == decodePkg::opJalr);
			r.link = (op == decodePkg::opJal) || (op == decodePkg::opJalr);
			r.regWrite = r.link;
			r.regDst = decodePkg::dstR7;
			r.signImm = 1'b1;
		end
		decodePkg::opBtr: begin
			r.regWrite = 1'b1;
			r.regDst = decodePkg::dstRd;
			r.specialOp = decodePkg::spBtr;
			r.clrAluSrc = 1'b1;
		end
		decodePkg::opLbi: begin
			r.regWrite = 1'b1;
			r.aluSrc = 1'b1;
			r.signImm = 1'b1;
			r.specialOp = decodePkg::spLbi;
		end
		decodePkg::opSlbi: begin
			r.regWrite = 1'b1;
			r.aluSrc = 1'b1;
			r.specialOp = decodePkg::spSlbi;
			r.aluOp = decodePkg::aluOr;
		end
		default: r.err = 1'b1;		// 00010 and 00011
	endcase
	return r;
endfunction

function automatic decodePkg::word_t refImm(input decodePkg::word_t instr, input ctrlRef_t e);
	if (e.imm5)
		return {{11{e.signImm & instr[4]}}, instr[4:0]};
	return {{8{e.signImm & instr[7]}}, instr[7:0]};
endfunction

function automatic decodePkg::regSel_t refDest(input decodePkg::word_t instr, input ctrlRef_t e);
	case (e.regDst)
		decodePkg::dstRs: return instr[10:8];
		decodePkg::dstRt: return instr[7:5];
		decodePkg::dstRd: return instr[4:2];
		default: return decodePkg::linkReg;
	endcase
endfunction

function automatic logic refTaken(input decodePkg::word_t instr, input ctrlRef_t e,
		input decodePkg::word_t rsVal);
	if (!(e.branch || e.jumpD))
		return 1'b0;
	if (e.jumpD)
		return 1'b1;
	case (instr[12:11])
		2'b00: return rsVal == 16'h0000;
		2'b01: return rsVal != 16'h0000;
		2'b10: return $signed(rsVal) < 0;
		default: return $signed(rsVal) >= 0;
	endcase
endfunction

function automatic decodePkg::word_t refTarget(input decodePkg::word_t instr, input ctrlRef_t e,
		input decodePkg::word_t rsVal, input decodePkg::word_t pc);
	if (e.branch)
		return pc + refImm(instr, e);
	if (e.jumpI)
		return rsVal + refImm(instr, e);		// jr, jalr
	return pc + {{5{instr[10]}}, instr[10:0]};
endfunction

// reset clears every shadow register, otherwise an enabled write lands
task automatic updateShadow(input logic rstNow, input decodePkg::word_t instr, input ctrlRef_t e,
		input decodePkg::word_t wb);
	if (rstNow) begin
		for (int i = 0; i < 8; i++) begin
			shadowRegs[i] = '0;
		end
	end else if (e.regWrite) begin
		shadowRegs[refDest(instr, e)] = wb;
	end
endtask

// ==== dv/decodeTb.sv ====
/*
	Decode stage testbench
	Seeded random instructions against a reference model, covering
	register write-back, control decode, immediates, branches and errors
*/
`timescale 1ns/100ps

module decodeTb;

	localparam int numInstr = 400;
	localparam int clkPeriod = 8;

	logic clk;
	logic rst;
	decodePkg::word_t instruction;
	decodePkg::word_t wbData;
	decodePkg::word_t pcPlusTwo;
	logic err;
	decodePkg::word_t read1Data;
	decodePkg::word_t read2Data;
	decodePkg::word_t immExt;
	decodePkg::aluOp_t aluOp;
	logic aluSrc, clrAluSrc, cin, invA, invB, sign;
	logic halt, createDump, jumpI, memWrite, memRead, cmpSet;
	decodePkg::cmpOp_t cmpOp;
	logic memToReg, link;
	decodePkg::specialOp_t specialOp;
	logic branchTaken;
	decodePkg::word_t branchTarget;

	int errCount;
	int checkCount;

	`include "decodeModel.svh"

	decode UUT (.*);

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	task automatic checkVal(input string name, input logic [15:0] expV, input logic [15:0] actV);
		checkCount++;
		if (actV !== expV) begin
			errCount++;
			$display("ERR %0t ns: %s expected %h, got %h", $time, name, expV, actV);
		end
	endtask

	// drive on the falling edge and check just before the rising edge
	task automatic applyInstr(input logic rstVal, input decodePkg::word_t instr,
			input decodePkg::word_t wb, input decodePkg::word_t pc);
		ctrlRef_t e;
		decodePkg::word_t rsVal;
		@(negedge clk);
		rst = rstVal;
		instruction = instr;
		wbData = wb;
		pcPlusTwo = pc;
		e = refDecode(instr);
		rsVal = shadowRegs[instr[10:8]];
		#(clkPeriod / 2 - 1);
		checkVal("err", 16'(e.err | (e.regWrite & $isunknown(wb))), 16'(err));
		checkVal("read1Data", rsVal, read1Data);		// old value on a same-cycle write
		checkVal("read2Data", shadowRegs[instr[7:5]], read2Data);
		checkVal("immExt", refImm(instr, e), immExt);
		checkVal("aluOp", 16'(e.aluOp), 16'(aluOp));
		checkVal("aluSrc", 16'(e.aluSrc), 16'(aluSrc));
		checkVal("clrAluSrc", 16'(e.clrAluSrc), 16'(clrAluSrc));
		checkVal("cin", 16'(e.cin), 16'(cin));
		checkVal("invA", 16'(e.invA), 16'(invA));
		checkVal("invB", 16'(e.invB), 16'(invB));
		checkVal("sign", 16'(e.sign), 16'(sign));
		checkVal("halt", 16'(e.halt), 16'(halt));
		checkVal("createDump", 16'(e.createDump), 16'(createDump));
		checkVal("jumpI", 16'(e.jumpI), 16'(jumpI));
		checkVal("memWrite", 16'(e.memWrite), 16'(memWrite));
		checkVal("memRead", 16'(e.memRead), 16'(memRead));
		checkVal("cmpSet", 16'(e.cmpSet), 16'(cmpSet));
		checkVal("cmpOp", 16'(e.cmpOp), 16'(cmpOp));
		checkVal("memToReg", 16'(e.memToReg), 16'(memToReg));
		checkVal("link", 16'(e.link), 16'(link));
		checkVal("specialOp", 16'(e.specialOp), 16'(specialOp));
		checkVal("branchTaken", 16'(refTaken(instr, e, rsVal)), 16'(branchTaken));
		if (e.branch || e.jumpD)
			checkVal("branchTarget", refTarget(instr, e, rsVal, pc), branchTarget);
		@(posedge clk);
		updateShadow(rstVal, instr, e, wb);
	endtask

	initial begin
		decodePkg::word_t instr;
		decodePkg::word_t wb;
		errCount = 0;
		checkCount = 0;
		void'($urandom(32'haf01));
		rst = 1'b1;
		instruction = {decodePkg::opNop, 11'h000};
		wbData = '0;
		pcPlusTwo = '0;
		for (int i = 0; i < 8; i++) begin
			shadowRegs[i] = '0;
		end

		// reset is four rising edges, the first one before any drive
		applyInstr(1'b1, {decodePkg::opAddi, 11'h123}, 'x, 16'h0002);	// unknown write-back
		applyInstr(1'b1, {5'b00010, 11'h7ff}, 16'h1234, 16'h0004);		// illegal opcode
		applyInstr(1'b1, {decodePkg::opNop, 11'h000}, 16'h0000, 16'h0006);

		for (int i = 0; i < 8; i++) begin
			instr = {decodePkg::opNop, 3'(i), 3'(7 - i), 5'h00};
			applyInstr(1'b0, instr, 16'(i * 16'h1111), 16'h0100);		// all zero after reset
		end

		for (int n = 0; n < numInstr; n++) begin
			instr = 16'($urandom);
			wb = ($urandom_range(0, 7) == 0) ? 16'h0000 : 16'($urandom);	// zero feeds beqz
			applyInstr(1'b0, instr, wb, 16'($urandom) & 16'hfffe);
		end

		$display("decodeTb: %0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// reset, read sweep and random run, plus margin
	initial begin
		#((numInstr + 3 + 8 + 40) * clkPeriod);
		$display("watchdog: stimulus did not complete within the expected time");
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== hdl/aluCtrlIf.sv ====
/*
	ALU control bundle
	Carries the execute-stage ALU controls from the decoder to the stage top
*/
`timescale 1ns/100ps

interface aluCtrlIf;

	decodePkg::aluOp_t aluOp;
	logic aluSrc;			// immediate as second operand
	logic clrAluSrc;		// force second operand to zero
	logic cin;
	logic invA;
	logic invB;
	logic sign;				// signed compare

	modport src (output aluOp, aluSrc, clrAluSrc, cin, invA, invB, sign);
	modport dst (input aluOp, aluSrc, clrAluSrc, cin, invA, invB, sign);

endinterface

// ==== hdl/branchResolve.sv ====
/*
	Branch resolve
	Evaluates the zero and sign tests on Rs and forms the branch or jump
	target, so control flow is settled inside the decode stage
*/
`timescale 1ns/100ps

module branchResolve (
	input logic branch,
	input logic jumpD,
	input logic [1:0] branchOp,
	input decodePkg::word_t rs,
	input decodePkg::word_t immExt,
	input decodePkg::word_t pcPlusTwo,
	input logic [10:0] disp,
	output logic taken,
	output decodePkg::word_t target
);

	logic cond;
	decodePkg::word_t dispExt;

	always_comb begin
		case (branchOp)
			2'b00: cond = (rs == '0);		// beqz
			2'b01: cond = (rs != '0);		// bnez
			2'b10: cond = rs[15];			// bltz
			default: cond = ~rs[15];		// bgez
		endcase
	end

	assign dispExt = {{5{disp[10]}}, disp};

	always_comb begin
		if (!jumpD)
			target = pcPlusTwo + immExt;
		else if (branchOp[0])
			target = rs + immExt;			// jr, jalr
		else
			target = pcPlusTwo + dispExt;	// j, jal
	end

	assign taken = jumpD | (branch & cond);

endmodule

// ==== hdl/decode.sv ====
/*
	Decode stage
	Register read and write-back, immediate extension, control decode and
	in-stage branch resolution for the 16-bit eight-register core
*/
`timescale 1ns/100ps

module decode (
	input logic clk,
	input logic rst,
	input decodePkg::word_t instruction,
	input decodePkg::word_t wbData,
	input decodePkg::word_t pcPlusTwo,
	output logic err,
	output decodePkg::word_t read1Data,
	output decodePkg::word_t read2Data,
	output decodePkg::word_t immExt,
	output decodePkg::aluOp_t aluOp,
	output logic aluSrc,
	output logic clrAluSrc,
	output logic cin,
	output logic invA,
	output logic invB,
	output logic sign,
	output logic halt,
	output logic createDump,
	output logic jumpI,
	output logic memWrite,
	output logic memRead,
	output logic cmpSet,
	output decodePkg::cmpOp_t cmpOp,
	output logic memToReg,
	output logic link,
	output decodePkg::specialOp_t specialOp,
	output logic branchTaken,
	output decodePkg::word_t branchTarget
);

	aluCtrlIf aluBus ();

	decodePkg::regDst_t regDst;
	decodePkg::regSel_t writeSel;
	logic regWrite;
	logic imm5, signImm;
	logic jumpD, branch;
	logic ctrlErr;

	always_comb begin
		case (regDst)
			decodePkg::dstRs: writeSel = instruction[10:8];
			decodePkg::dstRt: writeSel = instruction[7:5];
			decodePkg::dstRd: writeSel = instruction[4:2];
			default: writeSel = decodePkg::linkReg;
		endcase
	end

	always_comb begin
		if (imm5)
			immExt = signImm ? {{11{instruction[4]}}, instruction[4:0]} : {11'b0, instruction[4:0]};
		else
			immExt = signImm ? {{8{instruction[7]}}, instruction[7:0]} : {8'b0, instruction[7:0]};
	end

	regFile rf (
		.clk(clk),
		.rst(rst),
		.read1Sel(instruction[10:8]),
		.read2Sel(instruction[7:5]),
		.writeSel(writeSel),
		.writeData(wbData),
		.writeEn(regWrite),
		.read1Data(read1Data),
		.read2Data(read2Data)
	);

	decodeControl ctrl (
		.opcode(decodePkg::opcode_t'(instruction[15:11])),
		.funct(instruction[1:0]),
		.alu(aluBus.src),
		.halt(halt),
		.createDump(createDump),
		.jumpI(jumpI),
		.jumpD(jumpD),
		.branch(branch),
		.memWrite(memWrite),
		.memRead(memRead),
		.cmpSet(cmpSet),
		.memToReg(memToReg),
		.regWrite(regWrite),
		.link(link),
		.imm5(imm5),
		.signImm(signImm),
		.regDst(regDst),
		.cmpOp(cmpOp),
		.specialOp(specialOp),
		.err(ctrlErr)
	);

	branchResolve br (
		.branch(branch),
		.jumpD(jumpD),
		.branchOp(instruction[12:11]),
		.rs(read1Data),
		.immExt(immExt),
		.pcPlusTwo(pcPlusTwo),
		.disp(instruction[10:0]),
		.taken(branchTaken),
		.target(branchTarget)
	);

	assign aluOp = aluBus.aluOp;
	assign aluSrc = aluBus.aluSrc;
	assign clrAluSrc = aluBus.clrAluSrc;
	assign cin = aluBus.cin;
	assign invA = aluBus.invA;
	assign invB = aluBus.invB;
	assign sign = aluBus.sign;

	assign err = ctrlErr | (regWrite & $isunknown(wbData));	// X or Z write-back

	targetKnown: assert property (
		@(posedge clk) disable iff (rst)
		branchTaken |-> !$isunknown(branchTarget)
	) else $error("decode: taken with unknown target");

endmodule

// ==== hdl/decodeControl.sv ====
/*
	Decode control
	Turns the opcode and function bits into every execute, memory and
	write-back control, and flags opcodes outside the instruction set
*/
`timescale 1ns/100ps

module decodeControl (
	input decodePkg::opcode_t opcode,
	input logic [1:0] funct,
	aluCtrlIf.src alu,
	output logic halt,
	output logic createDump,
	output logic jumpI,
	output logic jumpD,
	output logic branch,
	output logic memWrite,
	output logic memRead,
	output logic cmpSet,
	output logic memToReg,
	output logic regWrite,
	output logic link,
	output logic imm5,
	output logic signImm,
	output decodePkg::regDst_t regDst,
	output decodePkg::cmpOp_t cmpOp,
	output decodePkg::specialOp_t specialOp,
	output logic err
);

	logic [1:0] aluSel;		// operation select shared by immediate and register forms

	assign aluSel = (opcode == decodePkg::opAlu || opcode == decodePkg::opShift) ?
		funct : opcode[1:0];

	always_comb begin
		halt = 1'b0;
		createDump = 1'b0;
		jumpI = 1'b0;
		jumpD = 1'b0;
		branch = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		cmpSet = 1'b0;
		memToReg = 1'b0;
		regWrite = 1'b0;
		link = 1'b0;
		imm5 = 1'b0;
		signImm = 1'b0;
		regDst = decodePkg::dstRs;
		cmpOp = decodePkg::cmpEq;
		specialOp = decodePkg::spNone;
		err = 1'b0;
		alu.aluOp = decodePkg::aluAdd;
		alu.aluSrc = 1'b0;
		alu.clrAluSrc = 1'b0;
		alu.cin = 1'b0;
		alu.invA = 1'b0;
		alu.invB = 1'b0;
		alu.sign = 1'b0;

		case (opcode)
			decodePkg::opHalt: begin
				halt = 1'b1;
				createDump = 1'b1;		// dump memory on halt
			end
			decodePkg::opNop: ;
			decodePkg::opAddi, decodePkg::opSubi, decodePkg::opXori, decodePkg::opAndni,
			decodePkg::opAlu: begin
				regWrite = 1'b1;
				regDst = (opcode == decodePkg::opAlu) ? decodePkg::dstRd : decodePkg::dstRt;
				imm5 = 1'b1;
				signImm = ~opcode[1];		// addi and subi are signed
				alu.aluSrc = (opcode != decodePkg::opAlu);
				case (aluSel)
					2'b00: alu.aluOp = decodePkg::aluAdd;
					2'b01: begin
						alu.aluOp = decodePkg::aluAdd;		// operand minus Rs
						alu.invA = 1'b1;
						alu.cin = 1'b1;
					end
					2'b10: alu.aluOp = decodePkg::aluXor;
					default: begin
						alu.aluOp = decodePkg::aluAnd;		// and-not
						alu.invB = 1'b1;
					end
				endcase
			end
			decodePkg::opRoli, decodePkg::opSlli, decodePkg::opSrai, decodePkg::opSrli,
			decodePkg::opShift: begin
				regWrite = 1'b1;
				regDst = (opcode == decodePkg::opShift) ? decodePkg::dstRd : decodePkg::dstRt;
				imm5 = 1'b1;
				alu.aluSrc = (opcode != decodePkg::opShift);
				alu.aluOp = decodePkg::aluOp_t'({1'b0, aluSel});	// shift codes are 0 to 3
			end
			decodePkg::opSt, decodePkg::opLd, decodePkg::opStu: begin
				imm5 = 1'b1;
				signImm = 1'b1;
				alu.aluSrc = 1'b1;		// address is Rs plus offset
				memRead = (opcode == decodePkg::opLd);
				memToReg = (opcode == decodePkg::opLd);
				memWrite = (opcode == decodePkg::opSt) || (opcode == decodePkg::opStu);
				regWrite = (opcode != decodePkg::opSt);
				regDst = (opcode == decodePkg::opLd) ? decodePkg::dstRt : decodePkg::dstRs;
			end
			decodePkg::opSeq, decodePkg::opSlt, decodePkg::opSle, decodePkg::opSco: begin
				regWrite = 1'b1;
				regDst = decodePkg::dstRd;
				cmpSet = 1'b1;
				alu.invB = (opcode != decodePkg::opSco);		// Rs minus Rt
				alu.cin = (opcode != decodePkg::opSco);
				alu.sign = (opcode == decodePkg::opSlt) || (opcode == decodePkg::opSle);
				case (opcode)
					decodePkg::opSeq: cmpOp = decodePkg::cmpEq;
					decodePkg::opSlt: cmpOp = decodePkg::cmpLt;
					decodePkg::opSle: cmpOp = decodePkg::cmpLe;
					default: cmpOp = decodePkg::cmpCo;
				endcase
			end
			decodePkg::opBeqz, decodePkg::opBnez, decodePkg::opBltz, decodePkg::opBgez: begin
				branch = 1'b1;
				signImm = 1'b1;
			end
			decodePkg::opJ, decodePkg::opJr, decodePkg::opJal, decodePkg::opJalr: begin
				jumpD = 1'b1;
				jumpI = opcode[0];		// register-relative forms
				signImm = 1'b1;
				link = opcode[1];
				regWrite = opcode[1];
				regDst = decodePkg::dstR7;
			end
			decodePkg::opBtr: begin
				regWrite = 1'b1;
				regDst = decodePkg::dstRd;
				specialOp = decodePkg::spBtr;
				alu.clrAluSrc = 1'b1;
			end
			decodePkg::opLbi, decodePkg::opSlbi: begin
				regWrite = 1'b1;
				alu.aluSrc = 1'b1;
				signImm = (opcode == decodePkg::opLbi);
				specialOp = (opcode == decodePkg::opLbi) ? decodePkg::spLbi : decodePkg::spSlbi;
				alu.aluOp = (opcode == decodePkg::opLbi) ? decodePkg::aluAdd : decodePkg::aluOr;
			end
			default: err = 1'b1;
		endcase
	end

	always_comb begin
		assert (!(memRead && memWrite)) else $error("decodeControl: load and store together");
	end

endmodule

// ==== hdl/decodePkg.sv ====
/*
	Decode package
	Word and field types, the opcode set and the ALU, compare,
	special-operation and destination encodings shared by the decode stage
*/
package decodePkg;

	typedef logic [15:0] word_t;		// data, instruction and address
	typedef logic [2:0] regSel_t;		// register number
	typedef logic [2:0] aluOp_t;
	typedef logic [1:0] cmpOp_t;
	typedef logic [1:0] specialOp_t;
	typedef logic [1:0] regDst_t;

	// ALU operations
	localparam aluOp_t aluRol = 3'b000;
	localparam aluOp_t aluSll = 3'b001;
	localparam aluOp_t aluSra = 3'b010;
	localparam aluOp_t aluSrl = 3'b011;
	localparam aluOp_t aluAdd = 3'b100;
	localparam aluOp_t aluAnd = 3'b101;
	localparam aluOp_t aluOr = 3'b110;
	localparam aluOp_t aluXor = 3'b111;

	localparam cmpOp_t cmpEq = 2'b00;
	localparam cmpOp_t cmpLt = 2'b01;
	localparam cmpOp_t cmpLe = 2'b10;
	localparam cmpOp_t cmpCo = 2'b11;		// carry out of Rs + Rt

	localparam specialOp_t spNone = 2'b00;
	localparam specialOp_t spBtr = 2'b01;
	localparam specialOp_t spLbi = 2'b10;
	localparam specialOp_t spSlbi = 2'b11;

	localparam regDst_t dstRs = 2'b00;		// instruction[10:8]
	localparam regDst_t dstRt = 2'b01;		// instruction[7:5]
	localparam regDst_t dstRd = 2'b10;		// instruction[4:2]
	localparam regDst_t dstR7 = 2'b11;

	localparam regSel_t linkReg = 3'd7;

	// 5'b00010 and 5'b00011 are not part of the set
	typedef enum logic [4:0] {
		opHalt = 5'b00000, opNop = 5'b00001,
		opJ = 5'b00100, opJr = 5'b00101, opJal = 5'b00110, opJalr = 5'b00111,
		opAddi = 5'b01000, opSubi = 5'b01001, opXori = 5'b01010, opAndni = 5'b01011,
		opBeqz = 5'b01100, opBnez = 5'b01101, opBltz = 5'b01110, opBgez = 5'b01111,
		opSt = 5'b10000, opLd = 5'b10001, opSlbi = 5'b10010, opStu = 5'b10011,
		opRoli = 5'b10100, opSlli = 5'b10101, opSrai = 5'b10110, opSrli = 5'b10111,
		opLbi = 5'b11000, opBtr = 5'b11001, opShift = 5'b11010, opAlu = 5'b11011,
		opSeq = 5'b11100, opSlt = 5'b11101, opSle = 5'b11110, opSco = 5'b11111
	} opcode_t;

endpackage

// ==== hdl/regFile.sv ====
/*
	Register file
	Eight 16-bit registers, two combinational read ports and one
	write port clocked on the rising edge, no write-to-read bypass
*/
`timescale 1ns/100ps

module regFile (
	input logic clk,
	input logic rst,
	input decodePkg::regSel_t read1Sel,
	input decodePkg::regSel_t read2Sel,
	input decodePkg::regSel_t writeSel,
	input decodePkg::word_t writeData,
	input logic writeEn,
	output decodePkg::word_t read1Data,
	output decodePkg::word_t read2Data
);

	decodePkg::word_t regs [0:7];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeSel] <= writeData;
		end
	end

	// same-cycle read of the write target sees the old value
	assign read1Data = regs[read1Sel];
	assign read2Data = regs[read2Sel];

	// write-back value must be fully known when it lands in a register
	wbKnown: assert property (
		@(posedge clk) disable iff (rst)
		writeEn |-> !$isunknown(writeData)
	) else $error("regFile: write of unknown data to r%0d", writeSel);

endmodule

// ==== project.f ====
+incdir+dv
hdl/decodePkg.sv
hdl/aluCtrlIf.sv
hdl/regFile.sv
hdl/decodeControl.sv
hdl/branchResolve.sv
hdl/decode.sv
dv/decodeTb.sv
